//--- rtl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // ====================
    // Bus timing
    // ====================
    localparam int CLK_FREQ       = 100_000_000;  // System clock in Hz
    localparam int SCL_FREQ       = 100_000;      // Bus clock in Hz
    localparam int QUARTER_CYCLES = CLK_FREQ / (SCL_FREQ * 4);
    localparam int QUARTER_CNT_W  = 8;            // Holds 0 .. QUARTER_CYCLES-1

    localparam int ADDR_W = 7;
    localparam int DATA_W = 8;

    // Commands from sequencer to bus engine
    typedef enum logic [1:0] {
        BIT_START = 2'd0,
        BIT_STOP  = 2'd1,
        BIT_WRITE = 2'd2,
        BIT_READ  = 2'd3
    } bit_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_START    = 3'd1,
        ST_ADDR     = 3'd2,
        ST_ADDR_ACK = 3'd3,
        ST_DATA     = 3'd4,
        ST_DATA_ACK = 3'd5,
        ST_STOP     = 3'd6
    } xfer_state_e;

    // Engine steps; PH_Q4 is the one-cycle finish step
    typedef enum logic [2:0] {
        PH_IDLE = 3'd0,
        PH_Q0   = 3'd1,
        PH_Q1   = 3'd2,
        PH_Q2   = 3'd3,
        PH_Q3   = 3'd4,
        PH_Q4   = 3'd5
    } bus_phase_e;

endpackage

`default_nettype wire

//--- rtl/i2c_bit_if.sv
`timescale 1ns/100ps
`default_nettype none

interface i2c_bit_if;
    import i2c_pkg::*;

    logic     cmd_valid;  // One-cycle command strobe
    bit_cmd_e cmd;
    logic     wr_bit;     // High releases SDA in a write slot
    logic     done;       // One-cycle end of bus action
    logic     rd_bit;     // SDA sampled in first high quarter

    modport sequencer (
        output cmd_valid,
        output cmd,
        output wr_bit,
        input  done,
        input  rd_bit
    );

    modport engine (
        input  cmd_valid,
        input  cmd,
        input  wr_bit,
        output done,
        output rd_bit
    );

endinterface

`default_nettype wire

//--- rtl/i2c_bus_engine.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_bus_engine (
    input  logic      clk,
    input  logic      rst_n,
    i2c_bit_if.engine bus,
    input  logic      sda_in,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_oe
);
    import i2c_pkg::*;

    logic [QUARTER_CNT_W-1:0] quarter_cnt;
    bus_phase_e               step;
    bit_cmd_e                 cmd_q;
    logic                     wr_q;
    logic                     seg_half;      // Second quarter of a START/STOP segment
    logic                     rd_q;
    logic                     quarter_end;
    logic                     quarter_mid;
    logic                     is_cond;
    logic                     last_quarter;
    logic                     active;

    assign quarter_end  = (quarter_cnt == QUARTER_CNT_W'(QUARTER_CYCLES - 1));
    assign quarter_mid  = (quarter_cnt == QUARTER_CNT_W'(QUARTER_CYCLES / 2));
    assign is_cond      = (cmd_q == BIT_START) || (cmd_q == BIT_STOP);
    assign last_quarter = is_cond ? ((step == PH_Q2) && seg_half) : (step == PH_Q3);
    assign active       = (step != PH_IDLE) && (step != PH_Q4);

    // ====================
    // Step sequencing
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step        <= PH_IDLE;
            quarter_cnt <= '0;
            seg_half    <= 1'b0;
            cmd_q       <= BIT_STOP;
            wr_q        <= 1'b1;
        end else begin
            case (step)
                PH_IDLE: begin
                    if (bus.cmd_valid) begin
                        step        <= PH_Q0;
                        quarter_cnt <= '0;
                        seg_half    <= 1'b0;
                        cmd_q       <= bus.cmd;
                        wr_q        <= bus.wr_bit;
                    end
                end
                PH_Q4: step <= PH_IDLE;  // done is high here
                default: begin
                    if (quarter_end) begin
                        quarter_cnt <= '0;
                        if (last_quarter) begin
                            step <= PH_Q4;
                        end else if (is_cond && !seg_half) begin
                            seg_half <= 1'b1;
                        end else begin
                            seg_half <= 1'b0;
                            step     <= bus_phase_e'(step + 3'd1);
                        end
                    end else begin
                        quarter_cnt <= quarter_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ====================
    // Bus levels
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;  // Idle bus is high
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else if (active) begin
            case (cmd_q)
                BIT_START: begin
                    scl     <= (step != PH_Q2);
                    sda_out <= (step == PH_Q0);  // Falls while SCL high
                    sda_oe  <= 1'b1;
                end
                BIT_STOP: begin
                    scl <= (step != PH_Q0);
                    // SDA goes low only once SCL has settled low
                    if ((step != PH_Q0) || seg_half) begin
                        sda_out <= (step == PH_Q2);
                        sda_oe  <= 1'b1;
                    end
                end
                default: begin
                    scl <= (step == PH_Q2) || (step == PH_Q3);
                    // Open drain data, a one releases the line
                    if ((step == PH_Q0) && quarter_mid) begin
                        sda_out <= wr_q;
                        sda_oe  <= (cmd_q == BIT_WRITE) && !wr_q;
                    end
                end
            endcase
        end
    end

    // Sample in the middle of the first high quarter
    always_ff @(posedge clk) begin
        if ((step == PH_Q2) && quarter_mid && !is_cond) begin
            rd_q <= sda_in;
        end
    end

    assign bus.done   = (step == PH_Q4);
    assign bus.rd_bit = rd_q;

    // One command in flight at a time
    a_no_cmd_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        bus.cmd_valid |-> (step == PH_IDLE));

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        bus.done |=> !bus.done);

endmodule

`default_nettype wire

//--- rtl/i2c_xfer_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_xfer_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      rw_bit,
    input  logic [i2c_pkg::ADDR_W-1:0] slave_addr,
    input  logic [i2c_pkg::DATA_W-1:0] tx_data,
    output logic [i2c_pkg::DATA_W-1:0] rx_data,
    output logic                      busy,
    output logic                      done,
    output logic                      ack_error,
    i2c_bit_if.sequencer              bus
);
    import i2c_pkg::*;

    xfer_state_e       state;
    logic [DATA_W-1:0] shift_q;  // Address byte first, then data
    logic [DATA_W-1:0] tx_q;
    logic              rw_q;
    logic [2:0]        bit_cnt;

    assign busy = (state != ST_IDLE);

    // ====================
    // Transaction FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            shift_q       <= '0;
            tx_q          <= '0;
            rw_q          <= 1'b0;
            bit_cnt       <= '0;
            rx_data       <= '0;
            ack_error     <= 1'b0;
            done          <= 1'b0;
            bus.cmd_valid <= 1'b0;
            bus.cmd       <= BIT_STOP;
            bus.wr_bit    <= 1'b1;
        end else begin
            bus.cmd_valid <= 1'b0;  // Strobes
            done          <= 1'b0;
            if (state == ST_IDLE) begin
                if (start) begin
                    shift_q       <= {slave_addr, rw_bit};
                    tx_q          <= tx_data;
                    rw_q          <= rw_bit;
                    ack_error     <= 1'b0;
                    state         <= ST_START;
                    bus.cmd_valid <= 1'b1;
                    bus.cmd       <= BIT_START;
                    bus.wr_bit    <= 1'b1;
                end
            end else if (bus.done) begin
                // Each finished bus action issues the next command
                case (state)
                    ST_START: begin
                        state         <= ST_ADDR;
                        bit_cnt       <= 3'd7;
                        bus.cmd_valid <= 1'b1;
                        bus.cmd       <= BIT_WRITE;
                        bus.wr_bit    <= shift_q[DATA_W-1];  // MSB first
                    end
                    ST_ADDR: begin
                        shift_q       <= {shift_q[DATA_W-2:0], bus.rd_bit};
                        bus.cmd_valid <= 1'b1;
                        bus.cmd       <= BIT_WRITE;
                        if (bit_cnt == 3'd0) begin
                            state      <= ST_ADDR_ACK;
                            bus.wr_bit <= 1'b1;  // Release for slave ACK
                        end else begin
                            bit_cnt    <= bit_cnt - 3'd1;
                            bus.wr_bit <= shift_q[DATA_W-2];
                        end
                    end
                    ST_ADDR_ACK: begin
                        bus.cmd_valid <= 1'b1;
                        if (bus.rd_bit) begin
                            ack_error <= 1'b1;  // No slave, skip data
                            state     <= ST_STOP;
                            bus.cmd   <= BIT_STOP;
                        end else begin
                            state      <= ST_DATA;
                            bit_cnt    <= 3'd7;
                            shift_q    <= tx_q;
                            bus.cmd    <= rw_q ? BIT_READ : BIT_WRITE;
                            bus.wr_bit <= rw_q | tx_q[DATA_W-1];
                        end
                    end
                    ST_DATA: begin
                        shift_q       <= {shift_q[DATA_W-2:0], bus.rd_bit};
                        bus.cmd_valid <= 1'b1;
                        if (bit_cnt == 3'd0) begin
                            state      <= ST_DATA_ACK;
                            bus.cmd    <= BIT_WRITE;
                            bus.wr_bit <= 1'b1;  // Slave ACK, or master NACK on read
                            if (rw_q) begin
                                rx_data <= {shift_q[DATA_W-2:0], bus.rd_bit};
                            end
                        end else begin
                            bit_cnt    <= bit_cnt - 3'd1;
                            bus.cmd    <= rw_q ? BIT_READ : BIT_WRITE;
                            bus.wr_bit <= rw_q | shift_q[DATA_W-2];
                        end
                    end
                    ST_DATA_ACK: begin
                        if (!rw_q && bus.rd_bit) begin
                            ack_error <= 1'b1;
                        end
                        state         <= ST_STOP;
                        bus.cmd_valid <= 1'b1;
                        bus.cmd       <= BIT_STOP;
                    end
                    ST_STOP: begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done));

    // Commands only go out inside a transaction
    a_cmd_in_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        bus.cmd_valid |-> (state != ST_IDLE));

endmodule

`default_nettype wire

//--- rtl/i2c_master.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_master (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       rw_bit,     // 1 is read
    input  logic [i2c_pkg::ADDR_W-1:0] slave_addr,
    input  logic [i2c_pkg::DATA_W-1:0] tx_data,
    output logic [i2c_pkg::DATA_W-1:0] rx_data,
    output logic                       busy,
    output logic                       done,
    output logic                       ack_error,
    inout  wire                        sda,
    output logic                       scl
);

    logic sda_out;
    logic sda_oe;
    logic sda_in;

    i2c_bit_if bit_bus ();

    // ====================
    // SDA pad
    // ====================
    assign sda    = sda_oe ? sda_out : 1'bz;
    assign sda_in = sda;

    i2c_xfer_sequencer i_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rw_bit     (rw_bit),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error),
        .bus        (bit_bus.sequencer)
    );

    i2c_bus_engine i_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bit_bus.engine),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

endmodule

`default_nettype wire

//--- testbench/i2c_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_model (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       scl,
    inout  wire        sda,
    input  logic [6:0] own_addr,
    input  logic       nack_data,
    input  logic [7:0] read_byte,
    output logic [7:0] addr_byte,
    output logic [7:0] data_byte,
    output logic [3:0] byte_count,   // Bytes received since START
    output logic       master_ack    // Master's answer after a read byte
);

    logic       scl_q;
    logic       sda_q;
    logic       sda_low;
    logic       in_xfer;
    logic       armed;      // Rising SCL seen in this slot
    logic       selected;
    logic       is_read;
    logic [3:0] slot;       // 0..7 data bits, 8 is the ack slot
    logic [1:0] byte_idx;
    logic [7:0] shift;
    logic [7:0] rd_shift;

    assign sda = sda_low ? 1'b0 : 1'bz;

    // Sampled on the falling clock edge, where the bus is settled
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            sda_low    <= 1'b0;
            in_xfer    <= 1'b0;
            armed      <= 1'b0;
            selected   <= 1'b0;
            is_read    <= 1'b0;
            slot       <= '0;
            byte_idx   <= '0;
            shift      <= '0;
            rd_shift   <= '0;
            addr_byte  <= '0;
            data_byte  <= '0;
            byte_count <= '0;
            master_ack <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin
                in_xfer    <= 1'b1;  // START
                armed      <= 1'b0;
                slot       <= '0;
                byte_idx   <= '0;
                byte_count <= '0;
                selected   <= 1'b0;
                is_read    <= 1'b0;
                sda_low    <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                in_xfer <= 1'b0;     // STOP
                sda_low <= 1'b0;
            end else if (in_xfer && scl && !scl_q) begin
                armed <= 1'b1;
                if (slot < 4'd8) begin
                    shift <= {shift[6:0], sda};
                end else if ((byte_idx == 2'd1) && is_read) begin
                    master_ack <= sda;
                end
            end else if (in_xfer && armed && !scl && scl_q) begin
                // End of a slot, SCL is low now
                armed   <= 1'b0;
                sda_low <= 1'b0;
                if (slot == 4'd7) begin
                    slot <= 4'd8;
                    if (byte_idx == 2'd0) begin
                        addr_byte  <= shift;
                        byte_count <= byte_count + 4'd1;
                        selected   <= (shift[7:1] == own_addr);
                        is_read    <= shift[0];
                        sda_low    <= (shift[7:1] == own_addr);
                    end else if ((byte_idx == 2'd1) && !is_read) begin
                        byte_count <= byte_count + 4'd1;  // Any byte on the bus counts
                        if (selected) begin
                            data_byte <= shift;
                            sda_low   <= !nack_data;
                        end
                    end
                end else if (slot == 4'd8) begin
                    slot     <= '0;
                    byte_idx <= byte_idx + 2'd1;
                    if (selected && (byte_idx == 2'd0) && is_read) begin
                        rd_shift <= read_byte;
                        sda_low  <= !read_byte[7];
                    end
                end else begin
                    slot <= slot + 4'd1;
                    if (selected && (byte_idx == 2'd1) && is_read) begin
                        rd_shift <= {rd_shift[6:0], 1'b0};
                        sda_low  <= !rd_shift[6];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_i2c_master.sv
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int         TIMEOUT_CYCLES = 30000;  // One transfer is about 21000
    localparam logic [6:0] SLAVE_ADDR     = 7'h3A;
    localparam logic [6:0] OTHER_ADDR     = 7'h15;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic              rw_bit;
    logic [ADDR_W-1:0] slave_addr;
    logic [DATA_W-1:0] tx_data;
    logic [DATA_W-1:0] rx_data;
    logic              busy;
    logic              done;
    logic              ack_error;
    wire               sda;
    logic              scl;

    // Slave configuration and record
    logic [6:0]  own_addr;
    logic        nack_data;
    logic [7:0]  read_byte;
    logic [7:0]  addr_byte;
    logic [7:0]  data_byte;
    logic [3:0]  byte_count;
    logic        master_ack;

    logic [15:0] lfsr;
    int          check_count;
    int          error_count;

    pullup (sda);

    i2c_master i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .rw_bit     (rw_bit),
        .slave_addr (slave_addr),
        .tx_data    (tx_data),
        .rx_data    (rx_data),
        .busy       (busy),
        .done       (done),
        .ack_error  (ack_error),
        .sda        (sda),
        .scl        (scl)
    );

    i2c_slave_model i_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .scl        (scl),
        .sda        (sda),
        .own_addr   (own_addr),
        .nack_data  (nack_data),
        .read_byte  (read_byte),
        .addr_byte  (addr_byte),
        .data_byte  (data_byte),
        .byte_count (byte_count),
        .master_ack (master_ack)
    );

    always #50 clk = ~clk;

    // ====================
    // Helpers
    // ====================
    // Galois form, taps x^16 x^14 x^13 x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] value);
        int i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            value = {value[6:0], lfsr[0]};  // One step per bit
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic launch(input logic rw, input logic [6:0] addr, input logic [7:0] data);
        @(negedge clk);
        rw_bit     = rw;
        slave_addr = addr;
        tx_data    = data;
        start      = 1'b1;
        @(negedge clk);
        start      = 1'b0;
    endtask

    // Returns at the falling edge where done is high
    task automatic wait_for_done(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < TIMEOUT_CYCLES)) begin
            @(negedge clk);
            seen = done;
            cycles++;
        end
        if (!seen) begin
            error_count++;
            $display("timeout: no done pulse within %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic reset_values();
        @(negedge clk);
        compare_value("scl", 32'(scl), 32'd1);
        compare_value("sda", 32'(sda), 32'd1);
        compare_value("busy", 32'(busy), 32'd0);
        compare_value("done", 32'(done), 32'd0);
        compare_value("ack_error", 32'(ack_error), 32'd0);
    endtask

    task automatic write_with_ack();
        logic [7:0] data;
        logic       seen;
        random_byte(data);
        nack_data = 1'b0;
        launch(1'b0, SLAVE_ADDR, data);
        wait_for_done(seen);
        compare_value("ack_error", 32'(ack_error), 32'd0);
        compare_value("slave addr_byte", 32'(addr_byte), 32'({SLAVE_ADDR, 1'b0}));
        compare_value("slave data_byte", 32'(data_byte), 32'(data));
        compare_value("slave byte_count", 32'(byte_count), 32'd2);
    endtask

    task automatic read_back();
        logic [7:0] data;
        logic       seen;
        random_byte(data);
        read_byte = data;
        launch(1'b1, SLAVE_ADDR, 8'hFF);
        wait_for_done(seen);
        compare_value("rx_data", 32'(rx_data), 32'(data));
        compare_value("ack_error", 32'(ack_error), 32'd0);
        compare_value("slave master_ack", 32'(master_ack), 32'd1);  // NACK after last byte
    endtask

    task automatic address_nack();
        logic [7:0] data;
        logic       seen;
        random_byte(data);
        launch(1'b0, OTHER_ADDR, data);
        wait_for_done(seen);
        compare_value("ack_error", 32'(ack_error), 32'd1);
        compare_value("slave byte_count", 32'(byte_count), 32'd1);
    endtask

    task automatic write_data_nack();
        logic [7:0] data;
        logic       seen;
        random_byte(data);
        nack_data = 1'b1;
        launch(1'b0, SLAVE_ADDR, data);
        wait_for_done(seen);
        compare_value("slave data_byte", 32'(data_byte), 32'(data));
        compare_value("ack_error", 32'(ack_error), 32'd1);
        nack_data = 1'b0;
    endtask

    task automatic start_while_busy();
        logic [7:0] first;
        logic [7:0] second;
        logic       seen;
        int         done_count;
        random_byte(first);
        random_byte(second);
        launch(1'b0, SLAVE_ADDR, first);
        repeat (2000) @(negedge clk);  // Well into the address byte
        compare_value("busy", 32'(busy), 32'd1);
        launch(1'b1, OTHER_ADDR, second);
        wait_for_done(seen);
        done_count = seen ? 1 : 0;
        // Long enough to see a whole second transfer
        repeat (TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (done) begin
                done_count++;
            end
        end
        compare_value("done pulses", 32'(done_count), 32'd1);
        compare_value("busy", 32'(busy), 32'd0);
        compare_value("ack_error", 32'(ack_error), 32'd0);
        compare_value("slave addr_byte", 32'(addr_byte), 32'({SLAVE_ADDR, 1'b0}));
        compare_value("slave data_byte", 32'(data_byte), 32'(first));
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        rw_bit      = 1'b0;
        slave_addr  = '0;
        tx_data     = '0;
        own_addr    = SLAVE_ADDR;
        nack_data   = 1'b0;
        read_byte   = '0;
        lfsr        = 16'd41759;
        check_count = 0;
        error_count = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        write_with_ack();
        read_back();
        address_nack();
        write_data_nack();
        start_while_busy();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
rtl/i2c_pkg.sv
rtl/i2c_bit_if.sv
rtl/i2c_bus_engine.sv
rtl/i2c_xfer_sequencer.sv
rtl/i2c_master.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module tb_i2c_master -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
